// File: design/noc_cfg.svh
`ifndef NOC_CFG_SVH
`define NOC_CFG_SVH

// Source side
`define NOC_NODE_COUNT 4
`define NOC_NODE_W 2

// Packet fields
`define NOC_ID_W 5
`define NOC_INSTR_W 3
`define NOC_FRAG_W 16

// Reassembly buffer
`define NOC_BUFFER_SIZE 4
`define NOC_CLOCKS_TO_LIVE 64   // Idle cycles before an incomplete entry is dropped
`define NOC_TIME_W 16

`endif

// File: design/noc_pkg.sv
`include "noc_cfg.svh"

package noc_pkg;

    // One packet word, read either as four fragments or as the whole payload
    typedef union packed {
        logic [0:3][`NOC_FRAG_W-1:0] frag;     // frag[0] is the most significant
        logic [4*`NOC_FRAG_W-1:0]    payload;
    } packet_union;

endpackage

// File: design/packet_splitter.sv
`timescale 1ns/1ps
`include "noc_cfg.svh"

module packet_splitter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    node_req,
    input  noc_pkg::packet_union    node_data,
    input  logic [`NOC_NODE_W-1:0]  node_dest,
    input  logic [`NOC_ID_W-1:0]    node_id,
    input  logic [`NOC_INSTR_W-1:0] node_instr,
    input  logic [3:0]              node_mask,
    input  logic                    frag_grant,
    output logic                    node_ack,
    output logic                    frag_req,
    output logic [`NOC_FRAG_W-1:0]  frag_data,
    output logic [1:0]              frag_index,
    output logic                    frag_first,
    output logic [`NOC_NODE_W-1:0]  frag_dest,
    output logic [`NOC_ID_W-1:0]    frag_id,
    output logic [`NOC_INSTR_W-1:0] frag_instr
);
    import noc_pkg::*;

    packet_union pkt_q;
    logic [3:0]  mask_q;       // Fragments still to be sent
    logic        pend_q;       // Request latched, ack goes up next cycle
    logic        first_q;
    logic        accept;
    logic [1:0]  cur_idx;

    // New request only when idle and the previous handshake is closed
    assign accept = node_req && !node_ack && !pend_q && (mask_q == 4'b0000);

    // Lowest set mask bit is the next fragment
    always_comb begin
        cur_idx = 2'd0;
        for (int i = 3; i >= 0; i--) begin
            if (mask_q[i]) begin
                cur_idx = 2'(i);
            end
        end
    end

    assign frag_req   = |mask_q;
    assign frag_index = cur_idx;
    assign frag_data  = pkt_q.frag[cur_idx];
    assign frag_first = first_q;

    // Handshake and fragment walk
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            node_ack <= 1'b0;
            pend_q   <= 1'b0;
            mask_q   <= 4'b0000;
            first_q  <= 1'b0;
        end else begin
            if (accept) begin
                pend_q  <= 1'b1;
                mask_q  <= node_mask;   // Zero mask just gets acknowledged
                first_q <= 1'b1;
            end else if (frag_req && frag_grant) begin
                mask_q[cur_idx] <= 1'b0;
                first_q         <= 1'b0;
            end

            if (pend_q) begin
                node_ack <= 1'b1;
                pend_q   <= 1'b0;
            end else if (node_ack && !node_req) begin
                node_ack <= 1'b0;
            end
        end
    end

    // Packet fields held for the whole walk
    always_ff @(posedge clk) begin
        if (accept) begin
            pkt_q      <= node_data;
            frag_dest  <= node_dest;
            frag_id    <= node_id;
            frag_instr <= node_instr;
        end
    end

endmodule

// File: design/flit_arbiter.sv
`timescale 1ns/1ps
`include "noc_cfg.svh"

module flit_arbiter (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`NOC_NODE_COUNT-1:0]  frag_req,
    input  logic [`NOC_NODE_COUNT-1:0]  frag_first,
    input  logic [`NOC_FRAG_W-1:0]      frag_data  [`NOC_NODE_COUNT],
    input  logic [1:0]                  frag_index [`NOC_NODE_COUNT],
    input  logic [`NOC_NODE_W-1:0]      frag_dest  [`NOC_NODE_COUNT],
    input  logic [`NOC_ID_W-1:0]        frag_id    [`NOC_NODE_COUNT],
    input  logic [`NOC_INSTR_W-1:0]     frag_instr [`NOC_NODE_COUNT],
    input  logic                        collector_ready,
    output logic [`NOC_NODE_COUNT-1:0]  frag_grant,
    output logic                        flit_valid,
    output logic [`NOC_NODE_W-1:0]      flit_node,
    output logic [`NOC_FRAG_W-1:0]      flit_data,
    output logic [1:0]                  flit_index,
    output logic [`NOC_NODE_W-1:0]      flit_dest,
    output logic [`NOC_ID_W-1:0]        flit_id,
    output logic [`NOC_INSTR_W-1:0]     flit_instr
);

    localparam int N = `NOC_NODE_COUNT;

    logic [N-1:0]             elig;
    logic [`NOC_NODE_W-1:0]   ptr_q;    // Node with top priority this cycle
    logic [`NOC_NODE_W-1:0]   cand;
    logic [`NOC_NODE_W-1:0]   win;
    logic                     found;

    // Open packets keep flowing even when the collector is full
    assign elig = frag_req & ({N{collector_ready}} | ~frag_first);

    always_comb begin
        found = 1'b0;
        win   = ptr_q;
        cand  = ptr_q;
        for (int k = 0; k < N; k++) begin
            cand = ptr_q + `NOC_NODE_W'(k);
            if (!found && elig[cand]) begin
                found = 1'b1;
                win   = cand;
            end
        end
    end

    assign frag_grant = {{(N-1){1'b0}}, found} << win;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flit_valid <= 1'b0;
            ptr_q      <= '0;
        end else begin
            flit_valid <= found;
            if (found) begin
                ptr_q <= win + 1'b1;    // Rotate past the winner
            end
        end
    end

    // Bus fields follow the grant by one cycle
    always_ff @(posedge clk) begin
        if (found) begin
            flit_node  <= win;
            flit_data  <= frag_data[win];
            flit_index <= frag_index[win];
            flit_dest  <= frag_dest[win];
            flit_id    <= frag_id[win];
            flit_instr <= frag_instr[win];
        end
    end

endmodule

// File: design/packet_collector.sv
`timescale 1ns/1ps
`include "noc_cfg.svh"

module packet_collector (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flit_valid,
    input  logic [`NOC_NODE_W-1:0]  flit_node,
    input  logic [`NOC_FRAG_W-1:0]  flit_data,
    input  logic [1:0]              flit_index,
    input  logic [`NOC_NODE_W-1:0]  flit_dest,
    input  logic [`NOC_ID_W-1:0]    flit_id,
    input  logic [`NOC_INSTR_W-1:0] flit_instr,
    input  logic                    out_ack,
    output logic                    collector_ready,
    output logic                    out_req,
    output noc_pkg::packet_union    out_packet,
    output logic [`NOC_NODE_W-1:0]  out_node,
    output logic [`NOC_NODE_W-1:0]  out_dest,
    output logic [`NOC_ID_W-1:0]    out_id,
    output logic [`NOC_INSTR_W-1:0] out_instr
);
    import noc_pkg::*;

    localparam int SLOTS  = `NOC_BUFFER_SIZE;
    localparam int SLOT_W = $clog2(SLOTS);
    localparam int CNT_W  = $clog2(SLOTS + 1);

    logic [SLOTS-1:0]          ent_valid;
    logic [3:0]                ent_mask  [SLOTS];   // Bit i set once fragment i is in
    packet_union               ent_data  [SLOTS];
    logic [`NOC_TIME_W-1:0]    ent_time  [SLOTS];   // Cycle of the last fragment
    logic [`NOC_NODE_W-1:0]    ent_node  [SLOTS];
    logic [`NOC_NODE_W-1:0]    ent_dest  [SLOTS];
    logic [`NOC_ID_W-1:0]      ent_id    [SLOTS];
    logic [`NOC_INSTR_W-1:0]   ent_instr [SLOTS];

    logic [`NOC_TIME_W-1:0]    now_q;
    logic [SLOTS-1:0]          ent_done;
    logic [SLOTS-1:0]          ent_expired;
    logic [SLOTS-1:0]          ent_free;
    logic                      match_found;
    logic                      open_found;
    logic                      done_found;
    logic [SLOT_W-1:0]         match_idx;
    logic [SLOT_W-1:0]         open_idx;
    logic [SLOT_W-1:0]         done_idx;
    logic [SLOT_W-1:0]         wr_idx;
    logic [SLOT_W-1:0]         out_sel;       // Entry being delivered
    logic [CNT_W-1:0]          free_cnt;
    logic                      store;
    logic                      launch;

    // Entry status
    always_comb begin
        for (int i = 0; i < SLOTS; i++) begin
            ent_done[i]    = ent_valid[i] && (&ent_mask[i]);
            ent_expired[i] = ent_valid[i] && !ent_done[i] &&
                             ((now_q - ent_time[i]) >= `NOC_TIME_W'(`NOC_CLOCKS_TO_LIVE));
            ent_free[i]    = !ent_valid[i] || ent_expired[i];
        end
    end

    // Lookups, scanned downward so the lowest index wins
    always_comb begin
        match_found = 1'b0;
        match_idx   = '0;
        open_found  = 1'b0;
        open_idx    = '0;
        done_found  = 1'b0;
        done_idx    = '0;
        free_cnt    = '0;
        for (int i = SLOTS - 1; i >= 0; i--) begin
            if (ent_valid[i] && !ent_expired[i] && ent_node[i] == flit_node &&
                ent_id[i] == flit_id && ent_instr[i] == flit_instr) begin
                match_found = 1'b1;
                match_idx   = SLOT_W'(i);
            end
            if (ent_free[i]) begin
                open_found = 1'b1;
                open_idx   = SLOT_W'(i);
                free_cnt   = free_cnt + 1'b1;
            end
            if (ent_done[i]) begin
                done_found = 1'b1;
                done_idx   = SLOT_W'(i);
            end
        end
    end

    assign store  = flit_valid && (match_found || open_found);
    assign wr_idx = match_found ? match_idx : open_idx;
    assign launch = !out_req && !out_ack && done_found;

    // Keep a slot back for a new packet already on the bus
    assign collector_ready = free_cnt > CNT_W'(flit_valid && !match_found);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            now_q     <= '0;
            ent_valid <= '0;
            out_req   <= 1'b0;
            out_sel   <= '0;
            for (int i = 0; i < SLOTS; i++) begin
                ent_mask[i] <= 4'b0000;
            end
        end else begin
            now_q <= now_q + 1'b1;

            // Drop stale incomplete entries
            for (int i = 0; i < SLOTS; i++) begin
                if (ent_expired[i]) begin
                    ent_valid[i] <= 1'b0;
                end
            end

            if (out_req && out_ack) begin
                out_req            <= 1'b0;
                ent_valid[out_sel] <= 1'b0;     // Entry is free again
            end else if (launch) begin
                out_req <= 1'b1;
                out_sel <= done_idx;
            end

            // Must come last so a reopened expired slot stays valid
            if (store) begin
                if (match_found) begin
                    ent_mask[wr_idx][flit_index] <= 1'b1;
                end else begin
                    ent_valid[wr_idx] <= 1'b1;
                    ent_mask[wr_idx]  <= 4'b0001 << flit_index;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (store) begin
            ent_data[wr_idx].frag[flit_index] <= flit_data;
            ent_time[wr_idx]                  <= now_q;
            if (!match_found) begin
                ent_node[wr_idx]  <= flit_node;
                ent_dest[wr_idx]  <= flit_dest;
                ent_id[wr_idx]    <= flit_id;
                ent_instr[wr_idx] <= flit_instr;
            end
        end
        if (launch) begin
            out_packet <= ent_data[done_idx];
            out_node   <= ent_node[done_idx];
            out_dest   <= ent_dest[done_idx];
            out_id     <= ent_id[done_idx];
            out_instr  <= ent_instr[done_idx];
        end
    end

endmodule

// File: design/noc_collect_top.sv
`timescale 1ns/1ps
`include "noc_cfg.svh"

module noc_collect_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`NOC_NODE_COUNT-1:0]  node_req,
    input  noc_pkg::packet_union        node_data  [`NOC_NODE_COUNT],
    input  logic [`NOC_NODE_W-1:0]      node_dest  [`NOC_NODE_COUNT],
    input  logic [`NOC_ID_W-1:0]        node_id    [`NOC_NODE_COUNT],
    input  logic [`NOC_INSTR_W-1:0]     node_instr [`NOC_NODE_COUNT],
    input  logic [3:0]                  node_mask  [`NOC_NODE_COUNT],
    output logic [`NOC_NODE_COUNT-1:0]  node_ack,
    output logic                        out_req,
    input  logic                        out_ack,
    output noc_pkg::packet_union        out_packet,
    output logic [`NOC_NODE_W-1:0]      out_node,
    output logic [`NOC_NODE_W-1:0]      out_dest,
    output logic [`NOC_ID_W-1:0]        out_id,
    output logic [`NOC_INSTR_W-1:0]     out_instr
);

    // Splitter to arbiter
    logic [`NOC_NODE_COUNT-1:0]  frag_req;
    logic [`NOC_NODE_COUNT-1:0]  frag_first;
    logic [`NOC_NODE_COUNT-1:0]  frag_grant;
    logic [`NOC_FRAG_W-1:0]      frag_data  [`NOC_NODE_COUNT];
    logic [1:0]                  frag_index [`NOC_NODE_COUNT];
    logic [`NOC_NODE_W-1:0]      frag_dest  [`NOC_NODE_COUNT];
    logic [`NOC_ID_W-1:0]        frag_id    [`NOC_NODE_COUNT];
    logic [`NOC_INSTR_W-1:0]     frag_instr [`NOC_NODE_COUNT];

    // Shared fragment bus
    logic                        flit_valid;
    logic [`NOC_NODE_W-1:0]      flit_node;
    logic [`NOC_FRAG_W-1:0]      flit_data;
    logic [1:0]                  flit_index;
    logic [`NOC_NODE_W-1:0]      flit_dest;
    logic [`NOC_ID_W-1:0]        flit_id;
    logic [`NOC_INSTR_W-1:0]     flit_instr;
    logic                        collector_ready;

    for (genvar n = 0; n < `NOC_NODE_COUNT; n++) begin : g_node
        packet_splitter i_split (
            .clk        (clk),
            .rst_n      (rst_n),
            .node_req   (node_req[n]),
            .node_data  (node_data[n]),
            .node_dest  (node_dest[n]),
            .node_id    (node_id[n]),
            .node_instr (node_instr[n]),
            .node_mask  (node_mask[n]),
            .frag_grant (frag_grant[n]),
            .node_ack   (node_ack[n]),
            .frag_req   (frag_req[n]),
            .frag_data  (frag_data[n]),
            .frag_index (frag_index[n]),
            .frag_first (frag_first[n]),
            .frag_dest  (frag_dest[n]),
            .frag_id    (frag_id[n]),
            .frag_instr (frag_instr[n])
        );
    end

    flit_arbiter i_arb (
        .clk             (clk),
        .rst_n           (rst_n),
        .frag_req        (frag_req),
        .frag_first      (frag_first),
        .frag_data       (frag_data),
        .frag_index      (frag_index),
        .frag_dest       (frag_dest),
        .frag_id         (frag_id),
        .frag_instr      (frag_instr),
        .collector_ready (collector_ready),
        .frag_grant      (frag_grant),
        .flit_valid      (flit_valid),
        .flit_node       (flit_node),
        .flit_data       (flit_data),
        .flit_index      (flit_index),
        .flit_dest       (flit_dest),
        .flit_id         (flit_id),
        .flit_instr      (flit_instr)
    );

    packet_collector i_coll (
        .clk             (clk),
        .rst_n           (rst_n),
        .flit_valid      (flit_valid),
        .flit_node       (flit_node),
        .flit_data       (flit_data),
        .flit_index      (flit_index),
        .flit_dest       (flit_dest),
        .flit_id         (flit_id),
        .flit_instr      (flit_instr),
        .out_ack         (out_ack),
        .collector_ready (collector_ready),
        .out_req         (out_req),
        .out_packet      (out_packet),
        .out_node        (out_node),
        .out_dest        (out_dest),
        .out_id          (out_id),
        .out_instr       (out_instr)
    );

endmodule

// File: tests/tb_noc_collect.sv
`timescale 1ns/1ps
`include "noc_cfg.svh"

module tb_noc_collect;
    import noc_pkg::*;

    localparam int NODES      = `NOC_NODE_COUNT;
    localparam int KEYS       = 1 << (`NOC_NODE_W + `NOC_ID_W + `NOC_INSTR_W);
    localparam int WAIT_LIMIT = 20000;   // Cycles

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic [NODES-1:0]        node_req;
    packet_union             node_data  [NODES];
    logic [`NOC_NODE_W-1:0]  node_dest  [NODES];
    logic [`NOC_ID_W-1:0]    node_id    [NODES];
    logic [`NOC_INSTR_W-1:0] node_instr [NODES];
    logic [3:0]              node_mask  [NODES];
    logic [NODES-1:0]        node_ack;
    logic                    out_req;
    logic                    out_ack;
    packet_union             out_packet;
    logic [`NOC_NODE_W-1:0]  out_node;
    logic [`NOC_NODE_W-1:0]  out_dest;
    logic [`NOC_ID_W-1:0]    out_id;
    logic [`NOC_INSTR_W-1:0] out_instr;

    // Reference record per key {node, id, instr}
    logic [15:0]             sent_frag [KEYS][4];
    int                      sent_time [KEYS][4];
    logic [3:0]              sent_mask [KEYS];
    logic [`NOC_NODE_W-1:0]  sent_dest [KEYS];

    logic [63:0]             job_data  [NODES][8];
    logic [`NOC_NODE_W-1:0]  job_dest  [NODES][8];
    logic [`NOC_ID_W-1:0]    job_id    [NODES][8];
    logic [`NOC_INSTR_W-1:0] job_instr [NODES][8];
    int                      next_id   [NODES];

    int          cyc = 0;
    int          outstanding = 0;   // Complete packets not yet delivered
    int          err_cnt = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    int          test_no = 0;
    int          test_base = 0;
    logic [31:0] rng_state = 32'd1;
    logic [31:0] ack_rng = 32'd1;
    logic        slow_ack = 1'b0;
    int          mon_state = 0;
    int          ack_wait = 0;
    logic        req_seen = 1'b0;
    logic        ack_prev = 1'b0;   // out_ack on the previous edge

    noc_collect_top i_dut (
        .clk(clk), .rst_n(rst_n), .node_req(node_req), .node_data(node_data),
        .node_dest(node_dest), .node_id(node_id), .node_instr(node_instr),
        .node_mask(node_mask), .node_ack(node_ack), .out_req(out_req), .out_ack(out_ack),
        .out_packet(out_packet), .out_node(out_node), .out_dest(out_dest),
        .out_id(out_id), .out_instr(out_instr)
    );

    always #50 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [15:0] draw16();
        rng_state = lcg_step(rng_state);
        return rng_state[31:16];
    endfunction

    function automatic int key_of(input int n, input int id, input int instr);
        return (n << (`NOC_ID_W + `NOC_INSTR_W)) | (id << `NOC_INSTR_W) | instr;
    endfunction

    // Merged word, valid only with all four fragments sent close enough in time
    function automatic logic expected_word(input int key, output logic [63:0] word);
        int t_min;
        int t_max;
        word  = '0;
        t_min = sent_time[key][0];
        t_max = t_min;
        for (int i = 0; i < 4; i++) begin
            word[63-16*i -: 16] = sent_frag[key][i];   // Fragment 0 on top
            t_min = (sent_time[key][i] < t_min) ? sent_time[key][i] : t_min;
            t_max = (sent_time[key][i] > t_max) ? sent_time[key][i] : t_max;
        end
        return (sent_mask[key] == 4'b1111) && (t_max - t_min < `NOC_CLOCKS_TO_LIVE);
    endfunction

    task automatic abort_run(input string why);
        $display("Run stopped at %0d ns: %s", $time, why);
        $display("Tests passed %0d, failed %0d", pass_cnt, fail_cnt + 1);
        $display("Testbench failed");
        $finish;
    endtask

    task automatic send_packet(input int n, input logic [63:0] data, input int dest,
                               input int id, input int instr, input logic [3:0] mask);
        int          waited;
        int          key;
        logic [63:0] word;
        logic        was_done;
        @(posedge clk);
        #10;
        node_data[n].payload = data;
        node_dest[n]  = dest;
        node_id[n]    = id;
        node_instr[n] = instr;
        node_mask[n]  = mask;
        node_req[n]   = 1'b1;
        for (waited = 0; !node_ack[n]; waited++) begin
            if (waited > WAIT_LIMIT) abort_run($sformatf("node %0d never got node_ack", n));
            @(posedge clk);
            #10;
        end
        key      = key_of(n, id, instr);
        was_done = expected_word(key, word);
        for (int i = 0; i < 4; i++) begin
            if (mask[i]) begin
                sent_frag[key][i] = data[63-16*i -: 16];
                sent_time[key][i] = cyc;
            end
        end
        sent_mask[key] = sent_mask[key] | mask;
        sent_dest[key] = dest;
        if (!was_done && expected_word(key, word)) outstanding++;
        node_req[n] = 1'b0;
        for (waited = 0; node_ack[n]; waited++) begin
            if (waited > WAIT_LIMIT) abort_run($sformatf("node %0d ack stayed high", n));
            @(posedge clk);
            #10;
        end
    endtask

    task automatic make_jobs(input int count);
        logic [15:0] r;
        for (int n = 0; n < NODES; n++) begin
            for (int k = 0; k < count; k++) begin
                for (int f = 0; f < 4; f++) job_data[n][k][63-16*f -: 16] = draw16();
                r = draw16();
                job_dest[n][k]  = r[1:0];
                job_instr[n][k] = r[4:2];
                job_id[n][k]    = `NOC_ID_W'(next_id[n]);   // Never reused in one run
                next_id[n]++;
            end
        end
    endtask

    // Every node sends its own list of full packets at the same time
    task automatic run_nodes(input int count);
        make_jobs(count);
        for (int n = 0; n < NODES; n++) begin
            fork
                automatic int node = n;
                for (int k = 0; k < count; k++) begin
                    send_packet(node, job_data[node][k], job_dest[node][k], job_id[node][k],
                                job_instr[node][k], 4'b1111);
                end
            join_none
        end
        wait fork;
    endtask

    task automatic drain(input int settle);
        for (int waited = 0; outstanding != 0; waited++) begin
            if (waited > WAIT_LIMIT) abort_run($sformatf("%0d packets never arrived", outstanding));
            @(posedge clk);
            #10;
        end
        repeat (settle) @(posedge clk);
    endtask

    task automatic end_test(input string name);
        test_no++;
        if (err_cnt == test_base) begin
            pass_cnt++;
            $display("Test %0d %s: ok", test_no, name);
        end else begin
            fail_cnt++;
            $display("Test %0d %s: %0d errors", test_no, name, err_cnt - test_base);
        end
        test_base = err_cnt;
    endtask

    task automatic check_delivery();
        int          key;
        logic [63:0] exp_word;
        key = key_of(out_node, out_id, out_instr);
        if (!expected_word(key, exp_word)) begin
            $display("Fail at %0d ns: unexpected packet node %0d id %0d instr %0d",
                     $time, out_node, out_id, out_instr);
            err_cnt++;
        end else begin
            if (out_packet.payload !== exp_word) begin
                $display("Fail at %0d ns: payload %h, expected %h", $time,
                         out_packet.payload, exp_word);
                err_cnt++;
            end
            if (out_dest !== sent_dest[key]) begin
                $display("Fail at %0d ns: dest %0d, expected %0d", $time, out_dest, sent_dest[key]);
                err_cnt++;
            end
            sent_mask[key] = 4'b0000;   // A second copy would now be unexpected
            outstanding--;
        end
    endtask

    // Endpoint side of the four-phase handshake
    always @(posedge clk) begin
        if (rst_n) begin
            // out_req was raised on the previous edge, so ack_prev is what the DUT saw
            if (out_req && !req_seen && ack_prev) begin
                $display("Fail at %0d ns: out_req rose before out_ack went low", $time);
                err_cnt++;
            end
            req_seen = out_req;
            ack_prev = out_ack;
            if (mon_state == 0 && out_req) begin
                check_delivery();
                ack_rng   = lcg_step(ack_rng);
                ack_wait  = slow_ack ? 16 + ack_rng[23:16] % 48 : ack_rng[17:16];
                mon_state = 1;
            end else if (mon_state == 1 && ack_wait == 0) begin
                out_ack   <= #10 1'b1;
                mon_state = 2;
            end else if (mon_state == 1) begin
                ack_wait--;
            end else if (mon_state == 2 && !out_req) begin
                out_ack   <= #10 1'b0;
                mon_state = 0;
            end else if (mon_state == 2) begin
                ack_wait++;
                if (ack_wait > WAIT_LIMIT) abort_run("out_req never dropped after out_ack");
            end
        end
    end

    initial begin
        rst_n    = 1'b0;
        node_req = '0;
        out_ack  = 1'b0;
        for (int n = 0; n < NODES; n++) begin
            node_data[n]  = '0;
            node_dest[n]  = '0;
            node_id[n]    = '0;
            node_instr[n] = '0;
            node_mask[n]  = 4'b0000;
            next_id[n]    = 0;
        end
        for (int k = 0; k < KEYS; k++) sent_mask[k] = 4'b0000;
        repeat (4) @(posedge clk);
        #10;
        rst_n = 1'b1;

        make_jobs(1);
        send_packet(1, job_data[1][0], job_dest[1][0], job_id[1][0], job_instr[1][0], 4'b1111);
        drain(10);
        end_test("single packet");

        run_nodes(4);
        drain(10);
        end_test("four nodes interleaved");

        // Two halves under one key
        make_jobs(2);
        send_packet(2, job_data[2][0], job_dest[2][0], job_id[2][0], job_instr[2][0], 4'b0101);
        send_packet(2, job_data[2][1], job_dest[2][0], job_id[2][0], job_instr[2][0], 4'b1010);
        drain(10);
        end_test("merged halves");

        // Fill every entry with halves, let them expire, then a late complement
        make_jobs(5);
        for (int k = 0; k < 4; k++) begin
            send_packet(3, job_data[3][k], job_dest[3][k], job_id[3][k], job_instr[3][k], 4'b0011);
        end
        repeat (2 * `NOC_CLOCKS_TO_LIVE) @(posedge clk);
        send_packet(3, job_data[3][0], job_dest[3][0], job_id[3][0], job_instr[3][0], 4'b1100);
        send_packet(3, job_data[3][4], job_dest[3][4], job_id[3][4], job_instr[3][4], 4'b1111);
        drain(2 * `NOC_CLOCKS_TO_LIVE);
        end_test("expired entries");

        slow_ack = 1'b1;
        run_nodes(5);
        drain(10);
        slow_ack = 1'b0;
        end_test("slow endpoint");

        $display("Tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+design
design/noc_pkg.sv
design/packet_splitter.sv
design/flit_arbiter.sv
design/packet_collector.sv
design/noc_collect_top.sv
tests/tb_noc_collect.sv

// File: Bender.yml
package:
  name: noc_collect

sources:
  - include_dirs:
      - design
    files:
      - design/noc_pkg.sv
      - design/packet_splitter.sv
      - design/flit_arbiter.sv
      - design/packet_collector.sv
      - design/noc_collect_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/tb_noc_collect.sv
